//--- Makefile
TOP := rv32_front_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f rv32_front.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TEST PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f rv32_front.f --top-module rv32_front

clean:
	rm -rf obj_dir sim.log

//--- rtl/rv32_fetch.sv
`include "rv32_macros.svh"

module rv32_fetch (
    input  logic                 clk,
    input  logic                 reset,

    // stall levels from the queue
    input  logic                 pcgen_stall,
    input  logic                 stall,
    input  logic                 flush,

    // redirects from the back end
    input  logic                 trap,
    input  logic                 branch_mispredicted,
    input  logic [31:0]          trap_pc,
    input  logic [31:0]          branch_pc,

    // fetch bus
    input  logic                 instr_fault,
    input  logic [31:0]          instr_read_value,
    output logic                 instr_read,
    output logic [31:0]          instr_address,

    // registered fetch entry
    output logic                 valid,
    output logic                 exception,
    output rv32_pkg::exc_cause_e exception_cause,
    output logic                 branch_predicted_taken,
    output logic [31:0]          pc,
    output logic [31:0]          instr
);
    import rv32_pkg::*;

    logic [31:0] fetch_pc;
    logic [31:0] next_pc;

    logic        redirect_pending;    // redirect seen while pcgen_stall was high
    logic [31:0] redirect_pc;

    logic        sign;
    logic [31:0] imm_j;
    logic [31:0] imm_b;
    opcode_e     opcode;

    logic        predict_taken;
    logic [31:0] pc_offset;
    logic        kill;

    assign instr_read    = 1'b1;    // memory is always read, no latency
    assign instr_address = fetch_pc;

    assign sign   = instr_read_value[31];
    assign opcode = opcode_e'(instr_read_value[6:0]);

    assign imm_j = {{12{sign}}, instr_read_value[19:12], instr_read_value[20],
                    instr_read_value[30:21], 1'b0};
    assign imm_b = {{20{sign}}, instr_read_value[7], instr_read_value[30:25],
                    instr_read_value[11:8], 1'b0};

    // static prediction: jal always, conditional branch only when backward
    always_comb begin
        predict_taken = 1'b0;
        pc_offset     = 32'd4;
        case (opcode)
            op_jal: begin
                predict_taken = 1'b1;
                pc_offset     = imm_j;
            end
            op_branch: begin
                if (sign) begin
                    predict_taken = 1'b1;
                    pc_offset     = imm_b;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        if (redirect_pending)
            next_pc = redirect_pc;
        else if (trap)
            next_pc = trap_pc;    // trap wins over a misprediction
        else if (branch_mispredicted)
            next_pc = branch_pc;
        else
            next_pc = fetch_pc + pc_offset;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc         <= `RV32_RESET_VECTOR;
            redirect_pending <= 1'b0;
        end else if (pcgen_stall) begin
            if (trap || branch_mispredicted)
                redirect_pending <= 1'b1;
        end else begin
            redirect_pending <= 1'b0;
            fetch_pc         <= next_pc;
        end
    end

    // only the first redirect of a stalled stretch is kept
    always_ff @(posedge clk) begin
        if (pcgen_stall && !redirect_pending && (trap || branch_mispredicted))
            redirect_pc <= trap ? trap_pc : branch_pc;
    end

    // wrong-path entry, either flushed or fetched before the latched redirect
    assign kill = flush || (!stall && redirect_pending);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid                  <= 1'b0;
            exception              <= 1'b0;
            branch_predicted_taken <= 1'b0;
        end else if (kill) begin
            valid                  <= 1'b0;
            exception              <= 1'b0;
            branch_predicted_taken <= 1'b0;
        end else if (!stall) begin
            valid                  <= !instr_fault;
            exception              <= instr_fault;
            branch_predicted_taken <= predict_taken && !instr_fault;
        end
    end

    always_ff @(posedge clk) begin
        if (kill) begin
            pc              <= '0;
            instr           <= `RV32_INSTR_NOP;
            exception_cause <= exc_none;
        end else if (!stall) begin
            pc              <= fetch_pc;
            instr           <= instr_fault ? `RV32_INSTR_NOP : instr_read_value;
            exception_cause <= instr_fault ? exc_instr_fault : exc_none;
        end
    end

endmodule

//--- rtl/rv32_fetch_queue.sv
`include "rv32_macros.svh"

module rv32_fetch_queue #(
    parameter int depth = `RV32_FQ_DEPTH
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 take,

    // entry from the fetch register
    input  logic                 valid,
    input  logic                 exception,
    input  rv32_pkg::exc_cause_e exception_cause,
    input  logic                 branch_predicted_taken,
    input  logic [31:0]          pc,
    input  logic [31:0]          instr,

    output logic                 stall,
    output logic                 pcgen_stall,

    // head of the queue
    output logic                 q_valid,
    output logic                 q_exception,
    output logic                 q_predicted_taken,
    output rv32_pkg::exc_cause_e q_cause,
    output logic [31:0]          q_pc,
    output logic [31:0]          q_instr
);
    import rv32_pkg::*;

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    localparam int cw = $clog2(depth + 1);

    logic [31:0] mem_pc [depth];
    logic [31:0] mem_instr [depth];
    logic        mem_exception [depth];
    logic        mem_taken [depth];
    exc_cause_e  mem_cause [depth];

    logic [aw-1:0] rd_ptr;
    logic [aw-1:0] wr_ptr;
    logic [cw-1:0] count;

    logic loaded;    // fetch register took a new entry on the last edge
    logic push;
    logic pop;

    assign push = loaded && (valid || exception);
    assign pop  = take && q_valid;

    // one free slot is kept for the entry already in the fetch register
    assign stall       = count >= cw'(depth - 1);
    assign pcgen_stall = stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            loaded <= 1'b0;
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            loaded <= !stall;
            if (flush) begin    // wrong-path entries are dropped
                rd_ptr <= '0;
                wr_ptr <= '0;
                count  <= '0;
            end else begin
                if (push)
                    wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
                if (pop)
                    rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
                if (push && !pop)
                    count <= count + 1'b1;
                else if (pop && !push)
                    count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem_pc[wr_ptr]        <= pc;
            mem_instr[wr_ptr]     <= instr;
            mem_exception[wr_ptr] <= exception;
            mem_taken[wr_ptr]     <= branch_predicted_taken;
            mem_cause[wr_ptr]     <= exception_cause;
        end
    end

    assign q_valid           = count != '0;
    assign q_exception       = q_valid && mem_exception[rd_ptr];
    assign q_predicted_taken = q_valid && mem_taken[rd_ptr];
    assign q_cause           = mem_cause[rd_ptr];
    assign q_pc              = mem_pc[rd_ptr];
    assign q_instr           = mem_instr[rd_ptr];

endmodule

//--- rtl/rv32_front.sv
module rv32_front (
    input  logic                 clk,
    input  logic                 reset,

    // consumer and back-end control
    input  logic                 take,
    input  logic                 flush,
    input  logic                 trap,
    input  logic                 branch_mispredicted,
    input  logic [31:0]          trap_pc,
    input  logic [31:0]          branch_pc,

    // program load port
    input  logic                 load_en,
    input  logic [31:0]          load_addr,
    input  logic [31:0]          load_data,

    // head of the fetch queue
    output logic                 q_valid,
    output logic                 q_exception,
    output logic                 q_predicted_taken,
    output rv32_pkg::exc_cause_e q_cause,
    output logic [31:0]          q_pc,
    output logic [31:0]          q_instr
);
    import rv32_pkg::*;

    // fetch bus
    logic        instr_read;
    logic [31:0] instr_address;
    logic [31:0] instr_read_value;
    logic        instr_fault;

    // fetch register to queue
    logic        valid;
    logic        exception;
    exc_cause_e  exception_cause;
    logic        branch_predicted_taken;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        stall;
    logic        pcgen_stall;

    rv32_fetch u_fetch (
        .clk                    (clk),
        .reset                  (reset),
        .pcgen_stall            (pcgen_stall),
        .stall                  (stall),
        .flush                  (flush),
        .trap                   (trap),
        .branch_mispredicted    (branch_mispredicted),
        .trap_pc                (trap_pc),
        .branch_pc              (branch_pc),
        .instr_fault            (instr_fault),
        .instr_read_value       (instr_read_value),
        .instr_read             (instr_read),
        .instr_address          (instr_address),
        .valid                  (valid),
        .exception              (exception),
        .exception_cause        (exception_cause),
        .branch_predicted_taken (branch_predicted_taken),
        .pc                     (pc),
        .instr                  (instr)
    );

    rv32_imem u_imem (
        .clk              (clk),
        .instr_read       (instr_read),
        .instr_address    (instr_address),
        .instr_read_value (instr_read_value),
        .instr_fault      (instr_fault),
        .load_en          (load_en),
        .load_addr        (load_addr),
        .load_data        (load_data)
    );

    rv32_fetch_queue u_queue (
        .clk                    (clk),
        .reset                  (reset),
        .flush                  (flush),
        .take                   (take),
        .valid                  (valid),
        .exception              (exception),
        .exception_cause        (exception_cause),
        .branch_predicted_taken (branch_predicted_taken),
        .pc                     (pc),
        .instr                  (instr),
        .stall                  (stall),
        .pcgen_stall            (pcgen_stall),
        .q_valid                (q_valid),
        .q_exception            (q_exception),
        .q_predicted_taken      (q_predicted_taken),
        .q_cause                (q_cause),
        .q_pc                   (q_pc),
        .q_instr                (q_instr)
    );

endmodule

//--- rtl/rv32_imem.sv
`include "rv32_macros.svh"

module rv32_imem #(
    parameter int words = `RV32_IMEM_WORDS
) (
    input  logic        clk,

    // fetch bus
    input  logic        instr_read,
    input  logic [31:0] instr_address,
    output logic [31:0] instr_read_value,
    output logic        instr_fault,

    // load port, byte addresses
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data
);
    localparam int aw = (words > 1) ? $clog2(words) : 1;

    logic [31:0] mem [words];

    logic        read_in_range;
    logic        load_in_range;
    logic [aw-1:0] read_index;
    logic [aw-1:0] load_index;

    assign read_index = instr_address[aw+1:2];
    assign load_index = load_addr[aw+1:2];

    // word aligned and below the end of the array
    assign read_in_range = (instr_address[1:0] == 2'b00)
                        && ({2'b00, instr_address[31:2]} < 32'(words));
    assign load_in_range = (load_addr[1:0] == 2'b00)
                        && ({2'b00, load_addr[31:2]} < 32'(words));

    always_ff @(posedge clk) begin
        if (load_en && load_in_range)
            mem[load_index] <= load_data;
    end

    always_comb begin
        instr_read_value = 32'd0;
        instr_fault      = 1'b0;
        if (instr_read) begin
            if (read_in_range)
                instr_read_value = mem[read_index];
            else
                instr_fault = 1'b1;    // data stays zero so fetch steps by 4
        end
    end

endmodule

//--- rtl/rv32_macros.svh
`ifndef RV32_MACROS_SVH
`define RV32_MACROS_SVH

// first pc fetched after reset
`define RV32_RESET_VECTOR 32'h0000_0000

// addi x0, x0, 0
`define RV32_INSTR_NOP 32'h0000_0013

// instruction memory depth in 32-bit words
`define RV32_IMEM_WORDS 256

// entries in the fetch queue, must leave room for the fetch register entry
`define RV32_FQ_DEPTH 4

`endif

//--- rtl/rv32_pkg.sv
package rv32_pkg;

    // major opcodes the static predictor looks at
    typedef enum logic [6:0] {
        op_jal    = 7'b1101111,
        op_branch = 7'b1100011,
        op_other  = 7'b0010011
    } opcode_e;

    // exception cause, numbered as in mcause
    typedef enum logic [3:0] {
        exc_none        = 4'd0,
        exc_instr_fault = 4'd1
    } exc_cause_e;

endpackage

//--- rv32_front.f
+incdir+rtl
rtl/rv32_pkg.sv
rtl/rv32_fetch.sv
rtl/rv32_imem.sv
rtl/rv32_fetch_queue.sv
rtl/rv32_front.sv
tb/rv32_front_tb.sv

//--- tb/rv32_front_tb.sv
`include "rv32_macros.svh"

module rv32_front_tb;
    import rv32_pkg::*;

    typedef struct packed {
        logic [1:0]  prog;         // 0 fill only, 1 branches, 2 jump out of memory
        logic [3:0]  take_div;     // 1 takes whenever an entry is there
        logic [1:0]  redir;        // bit 0 trap, bit 1 mispredict
        logic [7:0]  redir_cycle;
        logic [31:0] trap_tgt;
        logic [31:0] branch_tgt;
        logic [7:0]  n_check;
    } scen_t;

    localparam int n_scen = 8;

    scen_t scen [n_scen] = '{
        '{2'd0, 4'd1, 2'd0, 8'd0,  32'h0,   32'h0,   8'd12},
        '{2'd1, 4'd1, 2'd0, 8'd0,  32'h0,   32'h0,   8'd12},
        '{2'd0, 4'd1, 2'd1, 8'd8,  32'h80,  32'h0,   8'd12},
        '{2'd1, 4'd1, 2'd2, 8'd9,  32'h0,   32'h40,  8'd12},
        '{2'd0, 4'd1, 2'd3, 8'd7,  32'h100, 32'h200, 8'd10},
        '{2'd1, 4'd4, 2'd0, 8'd0,  32'h0,   32'h0,   8'd20},
        '{2'd0, 4'd5, 2'd1, 8'd30, 32'h20,  32'h0,   8'd20},
        '{2'd2, 4'd3, 2'd0, 8'd0,  32'h0,   32'h0,   8'd8}
    };
    string names [n_scen] = '{"reset_sequential", "static_predict", "trap_redirect",
                              "mispredict_redirect", "trap_over_mispredict", "backpressure",
                              "backpressure_redirect", "fault"};

    logic        clk;
    logic        reset;
    logic        take;
    logic        flush;
    logic        trap;
    logic        branch_mispredicted;
    logic        load_en;
    logic [31:0] trap_pc;
    logic [31:0] branch_pc;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic        q_valid;
    logic        q_exception;
    logic        q_predicted_taken;
    exc_cause_e  q_cause;
    logic [31:0] q_pc;
    logic [31:0] q_instr;

    // reference image of the memory, with the jump kind of each word
    logic [31:0] image [`RV32_IMEM_WORDS];
    logic [1:0]  kind [`RV32_IMEM_WORDS];    // 0 plain, 1 jal, 2 conditional branch
    int          offs [`RV32_IMEM_WORDS];

    logic [31:0] seed;
    logic [31:0] model_pc;
    int          cycle;
    int          checks;
    int          errors;
    int          failed_tests;
    int          test_errors;
    bit          redirect_now;

    rv32_front dut0 (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic logic [31:0] jal_word(input int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'd0, 7'b1101111};    // jal x0
    endfunction

    function automatic logic [31:0] branch_word(input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 10'd0, 3'b000, o[4:1], o[11], 7'b1100011};    // beq x0, x0
    endfunction

    task automatic set_jump(input int idx, input logic [1:0] k, input int off);
        kind[idx]  = k;
        offs[idx]  = off;
        image[idx] = (k == 2'd1) ? jal_word(off) : branch_word(off);
    endtask

    task automatic build_program(input logic [1:0] prog);
        logic [31:0] a;
        for (int i = 0; i < `RV32_IMEM_WORDS; i++) begin
            a        = 32'(i) << 2;
            image[i] = {a[11:0], 5'd1, 3'b000, 5'd1, 7'b0010011};    // addi x1, x1, addr
            kind[i]  = 2'd0;
            offs[i]  = 0;
        end
        if (prog == 2'd1) begin
            set_jump(1, 2'd2, 12);     // forward, falls through
            set_jump(2, 2'd1, 32);     // to 0x28
            set_jump(11, 2'd2, -40);   // back to 0x04
        end else if (prog == 2'd2) begin
            set_jump(1, 2'd1, 32'h3fc);    // lands just past the memory
        end
    endtask

    task automatic write_word(input int idx);
        @(negedge clk);
        load_en   = 1'b1;
        load_addr = 32'(idx) << 2;
        load_data = image[idx];
    endtask

    // only words 1, 2 and 11 differ between programs
    task automatic reset_and_load();
        take  = 1'b0;
        flush = 1'b0;
        trap  = 1'b0;
        branch_mispredicted = 1'b0;
        reset = 1'b1;
        write_word(1);
        write_word(2);
        write_word(11);
        @(negedge clk);
        load_en = 1'b0;
        reset   = 1'b0;
    endtask

    task automatic step_cycle(input scen_t s);
        @(negedge clk);
        cycle++;
        take  = 1'b0;
        flush = 1'b0;
        trap  = 1'b0;
        branch_mispredicted = 1'b0;
        redirect_now = (s.redir != 2'd0) && (cycle == int'(s.redir_cycle));
        if (redirect_now) begin
            trap      = s.redir[0];
            branch_mispredicted = s.redir[1];
            trap_pc   = s.trap_tgt;
            branch_pc = s.branch_tgt;
            flush     = 1'b1;
            model_pc  = s.redir[0] ? s.trap_tgt : s.branch_tgt;    // trap wins
        end
    endtask

    // compare the queue head with the next entry of the reference stream
    task automatic check_entry();
        logic [31:0] exp_instr;
        logic        fault;
        logic        taken;
        int          idx;
        idx   = int'(model_pc >> 2);
        fault = (model_pc[1:0] != 2'b00) || (idx >= `RV32_IMEM_WORDS);
        taken = !fault && (kind[idx] == 2'd1 || (kind[idx] == 2'd2 && offs[idx] < 0));
        exp_instr = fault ? `RV32_INSTR_NOP : image[idx];
        checks++;
        assert (q_pc == model_pc && q_instr == exp_instr && q_exception == fault
                && q_cause == (fault ? exc_instr_fault : exc_none)
                && q_predicted_taken == taken)
        else begin
            $display("FAILED %0t: got pc %h instr %h exc %b cause %0d taken %b", $time,
                     q_pc, q_instr, q_exception, q_cause, q_predicted_taken);
            $display("  expected pc %h instr %h exc %b taken %b",
                     model_pc, exp_instr, fault, taken);
            test_errors++;
        end
        model_pc = taken ? model_pc + 32'(offs[idx]) : model_pc + 32'd4;
    endtask

    initial begin
        int got;
        int waited;
        bit found;
        reset = 1'b1;
        take  = 1'b0;
        flush = 1'b0;
        trap  = 1'b0;
        branch_mispredicted = 1'b0;
        trap_pc   = '0;
        branch_pc = '0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        seed   = 32'ha95a;
        checks = 0;
        errors = 0;
        failed_tests = 0;
        build_program(2'd0);
        for (int i = 0; i < `RV32_IMEM_WORDS; i++)
            write_word(i);    // whole memory once, under reset
        for (int t = 0; t < n_scen; t++) begin
            build_program(scen[t].prog);
            reset_and_load();
            test_errors = 0;
            cycle    = 0;
            model_pc = `RV32_RESET_VECTOR;
            assert (!q_valid && !q_exception && !q_predicted_taken)
            else begin
                $display("FAILED %0t: queue outputs not cleared by reset", $time);
                test_errors++;
            end
            got = 0;
            while (got < int'(scen[t].n_check)) begin
                waited = 0;
                found  = 0;
                while (!found && waited < 100) begin
                    step_cycle(scen[t]);
                    waited++;
                    if (!redirect_now && q_valid
                        && ((lcg_next() >> 16) % 32'(scen[t].take_div)) == 0) begin
                        check_entry();
                        take  = 1'b1;
                        found = 1;
                    end
                end
                if (!found) begin
                    $display("timeout waiting for fetch entry in %s", names[t]);
                    test_errors++;
                    break;
                end
                got++;
            end
            $display("%s: %0d entries checked, %0d errors", names[t], got, test_errors);
            errors += test_errors;
            if (test_errors != 0)
                failed_tests++;
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 n_scen, failed_tests, checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
